/* exe_pkg.sv */
package exe_pkg;

	localparam int XLEN = 32;
	localparam int REG_ADDR_W = 5;
	localparam int PC_STEP = 4;
	localparam int FAULT_NUM_W = 7;

	// Vector number reported for a zero divisor
	localparam logic [FAULT_NUM_W-1:0] INT_NUM_DIVIDER_ERROR = 7'd3;

	typedef enum logic [3:0] {
		ADD,
		SUB,
		AND,
		OR,
		XOR,
		NOT,
		SHL,
		SHR,
		SAR,
		ROL,
		MUL,
		MULH,
		DIV,
		DIVU,
		MOD,
		MODU
	} exe_op_e;

	typedef struct packed {
		logic sf;
		logic of;
		logic cf;
		logic pf;
		logic zf;
	} exe_flags_t;

	typedef struct packed {
		logic valid;
		exe_op_e op;
		logic [REG_ADDR_W-1:0] dest;
		logic writeback;
		logic flags_writeback;
		logic [XLEN-1:0] src0;
		logic [XLEN-1:0] src1;
		logic [REG_ADDR_W-1:0] src0_ptr;
		logic [REG_ADDR_W-1:0] src1_ptr;
		logic src1_imm;
		logic [XLEN-1:0] pc;
	} exe_issue_t;

	typedef struct packed {
		logic valid;
		logic [XLEN-1:0] data;
		logic [REG_ADDR_W-1:0] dest;
		logic writeback;
	} exe_result_t;

endpackage

/* exe_forward.sv */
`timescale 1ns/10ps

module exe_forward
	import exe_pkg::*;
(
	input logic iCLOCK,
	input logic inRESET,
	input logic refresh,
	input exe_issue_t issue,
	input exe_result_t cur_result,
	output logic [XLEN-1:0] op0,
	output logic [XLEN-1:0] op1
);

	// Result one cycle older than cur_result
	exe_result_t hist_result;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			hist_result <= '0;
		end else if (refresh) begin
			hist_result <= '0;
		end else begin
			hist_result <= cur_result;
		end
	end

	// Newest matching result wins
	function automatic logic [XLEN-1:0] forward_value(
		input exe_result_t cur,
		input exe_result_t hist,
		input logic [REG_ADDR_W-1:0] ptr,
		input logic [XLEN-1:0] value
	);
		logic cur_hit;
		logic hist_hit;
		cur_hit = cur.valid && cur.writeback && (cur.dest == ptr);
		hist_hit = hist.valid && hist.writeback && (hist.dest == ptr);
		if (cur_hit) begin
			return cur.data;
		end else if (hist_hit) begin
			return hist.data;
		end
		return value;
	endfunction

	assign op0 = forward_value(cur_result, hist_result, issue.src0_ptr, issue.src0);

	// Immediate operand bypasses the history
	assign op1 = issue.src1_imm ? issue.src1
		: forward_value(cur_result, hist_result, issue.src1_ptr, issue.src1);

	// Operands seen by the units must be known whenever an issue is offered
	assert property (@(posedge iCLOCK) disable iff (!inRESET)
		issue.valid |-> !$isunknown({op0, op1}))
	else $error("forwarded operand unknown while issue is valid");

endmodule

/* exe_alu.sv */
`timescale 1ns/10ps

module exe_alu
	import exe_pkg::*;
(
	input exe_op_e op,
	input logic [XLEN-1:0] op0,
	input logic [XLEN-1:0] op1,
	output logic [XLEN-1:0] data,
	output exe_flags_t flags
);

	localparam int SHAMT_W = $clog2(XLEN);

	logic sub;
	logic [XLEN-1:0] addend;
	logic [XLEN-1:0] sum;
	logic carry;
	logic overflow;
	logic [SHAMT_W-1:0] shamt;
	logic [2*XLEN-1:0] rot;
	logic [2*XLEN-1:0] product;

	// Shared adder, SUB is op0 + ~op1 + 1
	assign sub = (op == SUB);
	assign addend = sub ? ~op1 : op1;
	assign {carry, sum} = {1'b0, op0} + {1'b0, addend} + {{XLEN{1'b0}}, sub};

	// Same-sign inputs giving a result of the other sign
	assign overflow = (op0[XLEN-1] == addend[XLEN-1]) && (sum[XLEN-1] != op0[XLEN-1]);

	assign shamt = op1[SHAMT_W-1:0];

	// Upper half of the doubled word is the left rotation
	assign rot = {op0, op0} << shamt;

	assign product = {{XLEN{1'b0}}, op0} * {{XLEN{1'b0}}, op1};

	always_comb begin
		data = sum;
		flags.of = 1'b0;
		flags.cf = 1'b0;
		case (op)
			ADD, SUB: begin
				data = sum;
				flags.cf = carry;
				flags.of = overflow;
			end
			AND: begin
				data = op0 & op1;
			end
			OR: begin
				data = op0 | op1;
			end
			XOR: begin
				data = op0 ^ op1;
			end
			NOT: begin
				data = ~op0;
			end
			SHL: begin
				data = op0 << shamt;
			end
			SHR: begin
				data = op0 >> shamt;
			end
			SAR: begin
				data = $signed(op0) >>> shamt;
			end
			ROL: begin
				data = rot[2*XLEN-1:XLEN];
			end
			MUL: begin
				data = product[XLEN-1:0];
				flags.cf = product[XLEN];
				flags.of = product[XLEN-1] ^ product[XLEN];
			end
			MULH: begin
				data = product[2*XLEN-1:XLEN];
			end
			default: begin
				// Divider ops take their result from exe_divider
				data = sum;
			end
		endcase
		flags.sf = data[XLEN-1];
		flags.pf = data[0];
		// High half zero test covers the whole product
		flags.zf = (op == MULH) ? (product == '0) : (data == '0);
	end

endmodule

/* exe_divider.sv */
`timescale 1ns/10ps

module exe_divider #(
	parameter int WIDTH = 32
) (
	input logic iCLOCK,
	input logic inRESET,
	input logic clear,
	input logic start,
	input logic sign,
	input logic [WIDTH-1:0] dividend,
	input logic [WIDTH-1:0] divisor,
	output logic done,
	output logic [WIDTH-1:0] q,
	output logic [WIDTH-1:0] r
);

	localparam int CNT_W = $clog2(WIDTH);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(WIDTH - 1);

	logic busy;
	logic [CNT_W-1:0] cnt;
	logic [WIDTH-1:0] quo;
	logic [WIDTH-1:0] rem;
	logic [WIDTH-1:0] dvs;
	logic neg_q;
	logic neg_r;
	logic [WIDTH:0] rem_shift;
	logic [WIDTH:0] diff;

	// Partial remainder with next dividend bit shifted in
	assign rem_shift = {rem, quo[WIDTH-1]};
	assign diff = rem_shift - {1'b0, dvs};

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			busy <= 1'b0;
			cnt <= '0;
			done <= 1'b0;
		end else if (clear) begin
			busy <= 1'b0;
			cnt <= '0;
			done <= 1'b0;
		end else begin
			done <= busy && (cnt == CNT_LAST);
			if (start) begin
				busy <= 1'b1;
				cnt <= '0;
			end else if (busy) begin
				cnt <= cnt + 1'b1;
				if (cnt == CNT_LAST) begin
					busy <= 1'b0;
				end
			end
		end
	end

	// Magnitudes go through the array, signs are restored at the output
	always_ff @(posedge iCLOCK) begin
		if (start) begin
			quo <= (sign && dividend[WIDTH-1]) ? -dividend : dividend;
			dvs <= (sign && divisor[WIDTH-1]) ? -divisor : divisor;
			rem <= '0;
			neg_q <= sign && (dividend[WIDTH-1] ^ divisor[WIDTH-1]);
			neg_r <= sign && dividend[WIDTH-1];
		end else if (busy) begin
			// No borrow means the divisor fits
			quo <= {quo[WIDTH-2:0], !diff[WIDTH]};
			rem <= diff[WIDTH] ? rem_shift[WIDTH-1:0] : diff[WIDTH-1:0];
		end
	end

	// Truncating division, remainder follows the dividend
	assign q = neg_q ? -quo : quo;
	assign r = neg_r ? -rem : rem;

	// The issuing side must hold off while a division runs
	assert property (@(posedge iCLOCK) disable iff (!inRESET)
		start |-> !busy)
	else $error("divider started while busy");

endmodule

/* exe_control.sv */
`timescale 1ns/10ps

module exe_control
	import exe_pkg::*;
(
	input logic iCLOCK,
	input logic inRESET,
	input logic stop,
	input logic refresh,
	input exe_issue_t issue,
	input logic [XLEN-1:0] op0,
	input logic [XLEN-1:0] op1,
	input logic [XLEN-1:0] alu_data,
	input exe_flags_t alu_flags,
	input logic div_done,
	input logic [XLEN-1:0] div_q,
	input logic [XLEN-1:0] div_r,
	output logic div_start,
	output logic div_sign,
	output logic div_clear,
	output exe_result_t cur_result,
	output exe_result_t result,
	output exe_flags_t flags,
	output logic lock,
	output logic fault_valid,
	output logic [FAULT_NUM_W-1:0] fault_num,
	output logic [XLEN-1:0] fault_pc
);

	typedef enum logic [1:0] {
		NORMAL,
		DIV_WAIT,
		FAULT
	} state_e;

	state_e state;
	logic accept;
	logic is_div;
	logic div_zero;
	logic rem_sel;
	logic res_valid;
	logic [XLEN-1:0] res_data;
	logic [REG_ADDR_W-1:0] res_dest;
	logic res_wb;
	exe_flags_t flags_r;

	assign lock = (state != NORMAL);
	assign accept = issue.valid && !lock && !stop;
	assign is_div = issue.op inside {DIV, DIVU, MOD, MODU};

	// Zero test uses the forwarded divisor
	assign div_zero = is_div && (op1 == '0);

	assign div_start = accept && is_div && !div_zero && !refresh;
	assign div_sign = (issue.op == DIV) || (issue.op == MOD);
	assign div_clear = refresh;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= NORMAL;
			res_valid <= 1'b0;
			fault_valid <= 1'b0;
			flags_r <= '0;
		end else if (refresh) begin
			state <= NORMAL;
			res_valid <= 1'b0;
			fault_valid <= 1'b0;
		end else begin
			case (state)
				NORMAL: begin
					res_valid <= accept && !is_div;
					if (accept && !is_div && issue.flags_writeback) begin
						flags_r <= alu_flags;
					end
					if (accept && div_zero) begin
						state <= FAULT;
						fault_valid <= 1'b1;
					end else if (accept && is_div) begin
						state <= DIV_WAIT;
					end
				end
				DIV_WAIT: begin
					res_valid <= div_done;
					if (div_done) begin
						state <= NORMAL;
					end
				end
				default: begin
					// Held here until refresh
					res_valid <= 1'b0;
					fault_valid <= 1'b0;
				end
			endcase
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (accept) begin
			res_data <= alu_data;
			res_dest <= issue.dest;
			res_wb <= issue.writeback;
			rem_sel <= (issue.op == MOD) || (issue.op == MODU);
			fault_pc <= issue.pc - XLEN'(PC_STEP);
		end else if ((state == DIV_WAIT) && div_done) begin
			res_data <= rem_sel ? div_r : div_q;
		end
	end

	assign cur_result = '{valid: res_valid, data: res_data, dest: res_dest, writeback: res_wb};

	always_comb begin
		result = cur_result;
		result.valid = cur_result.valid && !stop;
	end

	assign flags = flags_r;
	assign fault_num = INT_NUM_DIVIDER_ERROR;

	// A fault never coincides with a result or a finishing division
	assert property (@(posedge iCLOCK) disable iff (!inRESET || refresh)
		fault_valid |-> !cur_result.valid && !div_done)
	else $error("result produced alongside a divide fault");

	// Divider only finishes while the stage is locked waiting on it
	assert property (@(posedge iCLOCK) disable iff (!inRESET || refresh)
		div_done |-> lock && (state == DIV_WAIT))
	else $error("divider finished while the stage was not waiting on it");

endmodule

/* exe_top.sv */
`timescale 1ns/10ps

module exe_top
	import exe_pkg::*;
(
	input logic iCLOCK,
	input logic inRESET,
	input exe_issue_t issue,
	input logic stop,
	input logic refresh,
	output logic lock,
	output exe_result_t result,
	output exe_flags_t flags,
	output logic fault_valid,
	output logic [FAULT_NUM_W-1:0] fault_num,
	output logic [XLEN-1:0] fault_pc
);

	exe_result_t cur_result;
	logic [XLEN-1:0] op0;
	logic [XLEN-1:0] op1;
	logic [XLEN-1:0] alu_data;
	exe_flags_t alu_flags;
	logic div_start;
	logic div_sign;
	logic div_clear;
	logic div_done;
	logic [XLEN-1:0] div_q;
	logic [XLEN-1:0] div_r;

	exe_forward u_forward (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.refresh(refresh),
		.issue(issue),
		.cur_result(cur_result),
		.op0(op0),
		.op1(op1)
	);

	exe_alu u_alu (
		.op(issue.op),
		.op0(op0),
		.op1(op1),
		.data(alu_data),
		.flags(alu_flags)
	);

	exe_divider #(
		.WIDTH(XLEN)
	) u_divider (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.clear(div_clear),
		.start(div_start),
		.sign(div_sign),
		.dividend(op0),
		.divisor(op1),
		.done(div_done),
		.q(div_q),
		.r(div_r)
	);

	exe_control u_control (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.stop(stop),
		.refresh(refresh),
		.issue(issue),
		.op0(op0),
		.op1(op1),
		.alu_data(alu_data),
		.alu_flags(alu_flags),
		.div_done(div_done),
		.div_q(div_q),
		.div_r(div_r),
		.div_start(div_start),
		.div_sign(div_sign),
		.div_clear(div_clear),
		.cur_result(cur_result),
		.result(result),
		.flags(flags),
		.lock(lock),
		.fault_valid(fault_valid),
		.fault_num(fault_num),
		.fault_pc(fault_pc)
	);

endmodule

/* tb_exe_top.sv */
`timescale 1ns/10ps

module tb_exe_top
	import exe_pkg::*;
();

	localparam int HALF_PERIOD = 5;
	localparam int RESET_CYCLES = 5;
	// About 40 divisions of XLEN+2 cycles, plus room for the ALU tests
	localparam int TIMEOUT_CYCLES = 40 * (XLEN + 2) + 640;
	localparam int RESULT_WAIT = XLEN + 8;

	logic iCLOCK;
	logic inRESET;
	exe_issue_t issue;
	logic stop;
	logic refresh;
	logic lock;
	exe_result_t result;
	exe_flags_t flags;
	logic fault_valid;
	logic [FAULT_NUM_W-1:0] fault_num;
	logic [XLEN-1:0] fault_pc;

	integer seed;
	int errors;
	int checks;
	int cycles;
	// Expected content of the flags register
	exe_flags_t flags_exp;

	exe_top uut (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.issue(issue),
		.stop(stop),
		.refresh(refresh),
		.lock(lock),
		.result(result),
		.flags(flags),
		.fault_valid(fault_valid),
		.fault_num(fault_num),
		.fault_pc(fault_pc)
	);

	always #HALF_PERIOD iCLOCK = ~iCLOCK;

	always @(posedge iCLOCK) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Run timed out after %0d clock cycles", cycles);
			$display("Test failed");
			$finish;
		end
	end

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("ERROR: %s is %h, expected %h", name, got, want);
		end
	endtask

	task automatic report_failure(input string what);
		errors++;
		$display("%s", what);
	endtask

	task automatic next_cycle();
		@(posedge iCLOCK);
		#1;
	endtask

	function automatic exe_issue_t make_issue(input exe_op_e op, input logic [XLEN-1:0] src0,
		input logic [XLEN-1:0] src1);
		exe_issue_t i;
		i = '0;
		i.valid = 1'b1;
		i.op = op;
		i.dest = 5'd1;
		i.src0 = src0;
		i.src1 = src1;
		i.pc = 32'h100;
		return i;
	endfunction

	function automatic void alu_model(input exe_op_e op, input logic [XLEN-1:0] a,
		input logic [XLEN-1:0] b, output logic [XLEN-1:0] d, output exe_flags_t f);
		logic [XLEN:0] wide;
		logic [2*XLEN-1:0] prod;
		logic [4:0] sh;
		sh = b[4:0];
		prod = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};
		f = '0;
		d = '0;
		case (op)
			ADD: begin
				wide = {1'b0, a} + {1'b0, b};
				d = wide[XLEN-1:0];
				f.cf = wide[XLEN];
				f.of = (a[XLEN-1] == b[XLEN-1]) && (d[XLEN-1] != a[XLEN-1]);
			end
			SUB: begin
				wide = {1'b0, a} + {1'b0, ~b} + 33'd1;
				d = wide[XLEN-1:0];
				f.cf = wide[XLEN];
				f.of = (a[XLEN-1] != b[XLEN-1]) && (d[XLEN-1] != a[XLEN-1]);
			end
			AND: d = a & b;
			OR: d = a | b;
			XOR: d = a ^ b;
			NOT: d = ~a;
			SHL: d = a << sh;
			SHR: d = a >> sh;
			SAR: d = $signed(a) >>> sh;
			ROL: d = (a << sh) | (a >> (XLEN - sh));
			MUL: begin
				d = prod[XLEN-1:0];
				f.cf = prod[XLEN];
				f.of = prod[XLEN-1] ^ prod[XLEN];
			end
			MULH: d = prod[2*XLEN-1:XLEN];
			default: d = '0;
		endcase
		f.sf = d[XLEN-1];
		f.pf = d[0];
		f.zf = (op == MULH) ? (prod == '0) : (d == '0);
	endfunction

	function automatic logic [XLEN-1:0] div_model(input exe_op_e op, input logic [XLEN-1:0] a,
		input logic [XLEN-1:0] b);
		logic sgn;
		logic [XLEN-1:0] mag_a;
		logic [XLEN-1:0] mag_b;
		logic [XLEN-1:0] quo;
		logic [XLEN-1:0] rem;
		sgn = (op == DIV) || (op == MOD);
		mag_a = (sgn && a[XLEN-1]) ? -a : a;
		mag_b = (sgn && b[XLEN-1]) ? -b : b;
		quo = mag_a / mag_b;
		rem = mag_a % mag_b;
		// Truncation toward zero, remainder keeps the dividend's sign
		if (sgn && (a[XLEN-1] ^ b[XLEN-1])) begin
			quo = -quo;
		end
		if (sgn && a[XLEN-1]) begin
			rem = -rem;
		end
		return ((op == MOD) || (op == MODU)) ? rem : quo;
	endfunction

	task automatic alu_issue_check(input exe_op_e op, input logic [XLEN-1:0] a,
		input logic [XLEN-1:0] b, input logic fwb);
		logic [XLEN-1:0] d_exp;
		exe_flags_t f_exp;
		alu_model(op, a, b, d_exp, f_exp);
		issue = make_issue(op, a, b);
		issue.flags_writeback = fwb;
		next_cycle();
		issue.valid = 1'b0;
		if (fwb) begin
			flags_exp = f_exp;
		end
		check_value("result.valid", result.valid, 1'b1);
		check_value($sformatf("result.data for %s", op.name()), result.data, d_exp);
		check_value("flags", flags, flags_exp);
	endtask

	// Waits for a division result while lock must stay high
	task automatic wait_result(output logic seen);
		int n;
		logic lock_low;
		n = 0;
		lock_low = 1'b0;
		while (!result.valid && n < RESULT_WAIT) begin
			lock_low = lock_low || (lock !== 1'b1);
			next_cycle();
			n++;
		end
		seen = result.valid;
		if (lock_low) begin
			report_failure("lock dropped before the division result appeared");
		end
		if (!seen) begin
			report_failure("no division result appeared within the wait limit");
		end
	endtask

	task automatic div_issue_check(input exe_op_e op, input logic [XLEN-1:0] a,
		input logic [XLEN-1:0] b);
		logic seen;
		issue = make_issue(op, a, b);
		next_cycle();
		issue.valid = 1'b0;
		wait_result(seen);
		if (seen) begin
			check_value($sformatf("result.data for %s", op.name()), result.data,
				div_model(op, a, b));
			check_value("lock", lock, 1'b0);
		end
	endtask

	task automatic fault_and_refresh(input logic [XLEN-1:0] pc);
		logic [XLEN-1:0] pc_exp;
		int n;
		pc_exp = pc - XLEN'(PC_STEP);
		check_value("fault_valid", fault_valid, 1'b1);
		check_value("fault_num", fault_num, INT_NUM_DIVIDER_ERROR);
		check_value("fault_pc", fault_pc, pc_exp);
		check_value("result.valid", result.valid, 1'b0);
		check_value("lock", lock, 1'b1);
		for (n = 0; n < 4; n++) begin
			next_cycle();
			check_value("fault_valid", fault_valid, 1'b0);
			check_value("result.valid", result.valid, 1'b0);
			check_value("lock", lock, 1'b1);
		end
		refresh = 1'b1;
		next_cycle();
		refresh = 1'b0;
		check_value("lock", lock, 1'b0);
		check_value("flags", flags, flags_exp);
	endtask

	task automatic reset_state();
		check_value("result.valid", result.valid, 1'b0);
		check_value("lock", lock, 1'b0);
		check_value("fault_valid", fault_valid, 1'b0);
		check_value("flags", flags, 5'b0);
	endtask

	task automatic alu_ops();
		int i;
		int k;
		logic [XLEN-1:0] a;
		logic [XLEN-1:0] b;
		for (i = 0; i <= int'(MULH); i++) begin
			for (k = 0; k < 4; k++) begin
				a = $random(seed);
				b = $random(seed);
				alu_issue_check(exe_op_e'(i), a, b, k[0]);
			end
		end
		// Carry, overflow and zero corners
		alu_issue_check(ADD, 32'h7fffffff, 32'h1, 1'b1);
		alu_issue_check(ADD, 32'hffffffff, 32'h1, 1'b1);
		alu_issue_check(SUB, 32'h1234, 32'h1234, 1'b1);
		alu_issue_check(SUB, 32'h80000000, 32'h1, 1'b1);
		alu_issue_check(MUL, 32'h10000, 32'h10000, 1'b1);
		alu_issue_check(MULH, 32'h3, 32'h5, 1'b1);
		alu_issue_check(ROL, 32'h80000001, 32'h0, 1'b1);
		alu_issue_check(SAR, 32'h80000000, 32'h1f, 1'b0);
	endtask

	task automatic forwarding();
		exe_issue_t seq [5];
		logic [XLEN-1:0] want [5];
		int i;
		// r3 = 30
		seq[0] = make_issue(ADD, 32'd10, 32'd20);
		seq[0].dest = 5'd3;
		seq[0].writeback = 1'b1;
		want[0] = 32'd30;
		// r4 = r3 | 0 with r3 from the newest result
		seq[1] = make_issue(OR, 32'h111, 32'h0);
		seq[1].dest = 5'd4;
		seq[1].writeback = 1'b1;
		seq[1].src0_ptr = 5'd3;
		seq[1].src1_imm = 1'b1;
		want[1] = 32'd30;
		// r5 = r3 + r4, r3 now from the history
		seq[2] = make_issue(ADD, 32'h222, 32'h333);
		seq[2].dest = 5'd5;
		seq[2].writeback = 1'b1;
		seq[2].src0_ptr = 5'd3;
		seq[2].src1_ptr = 5'd4;
		want[2] = 32'd60;
		// Immediate 7 keeps its value although r5 matches
		seq[3] = make_issue(ADD, 32'h444, 32'd7);
		seq[3].dest = 5'd6;
		seq[3].src0_ptr = 5'd5;
		seq[3].src1_ptr = 5'd5;
		seq[3].src1_imm = 1'b1;
		want[3] = 32'd67;
		// r6 had no writeback, r5 from the history
		seq[4] = make_issue(ADD, 32'd100, 32'h555);
		seq[4].dest = 5'd7;
		seq[4].writeback = 1'b1;
		seq[4].src0_ptr = 5'd6;
		seq[4].src1_ptr = 5'd5;
		want[4] = 32'd160;
		for (i = 0; i < 5; i++) begin
			issue = seq[i];
			next_cycle();
			check_value("result.valid", result.valid, 1'b1);
			check_value($sformatf("result.data of forwarding step %0d", i), result.data,
				want[i]);
			check_value("result.dest", result.dest, seq[i].dest);
			check_value("result.writeback", result.writeback, seq[i].writeback);
		end
		issue.valid = 1'b0;
	endtask

	task automatic division();
		logic [XLEN-1:0] edge_a [4];
		logic [XLEN-1:0] edge_b [4];
		logic [XLEN-1:0] a;
		logic [XLEN-1:0] b;
		logic seen;
		int i;
		int k;
		edge_a[0] = 32'h80000000;
		edge_b[0] = 32'hffffffff;
		edge_a[1] = 32'hfffffff9;
		edge_b[1] = 32'h2;
		edge_a[2] = 32'h7;
		edge_b[2] = 32'hfffffffe;
		edge_a[3] = 32'hfffffff9;
		edge_b[3] = 32'hfffffffe;
		for (i = int'(DIV); i <= int'(MODU); i++) begin
			for (k = 0; k < 4; k++) begin
				a = $random(seed);
				b = $random(seed);
				if (b == '0) begin
					b = 32'd1;
				end
				div_issue_check(exe_op_e'(i), a, b);
				div_issue_check(exe_op_e'(i), edge_a[k], edge_b[k]);
			end
		end
		// ADD held during the division goes in once lock falls
		issue = make_issue(DIV, 32'd1000, 32'd7);
		next_cycle();
		issue = make_issue(ADD, 32'd5, 32'd6);
		wait_result(seen);
		if (seen) begin
			check_value("result.data for DIV", result.data, div_model(DIV, 32'd1000, 32'd7));
			next_cycle();
			issue.valid = 1'b0;
			check_value("result.valid", result.valid, 1'b1);
			check_value("result.data for held ADD", result.data, 32'd11);
		end
	endtask

	task automatic divide_by_zero();
		issue = make_issue(DIV, 32'd77, 32'd0);
		issue.pc = 32'h2000;
		next_cycle();
		issue.valid = 1'b0;
		fault_and_refresh(32'h2000);
		alu_issue_check(ADD, 32'd2, 32'd3, 1'b0);
		// Zero divisor arrives from r5 through forwarding
		issue = make_issue(ADD, 32'd0, 32'd0);
		issue.dest = 5'd5;
		issue.writeback = 1'b1;
		next_cycle();
		issue = make_issue(MODU, 32'd50, 32'd9);
		issue.src1_ptr = 5'd5;
		issue.pc = 32'h3004;
		next_cycle();
		issue.valid = 1'b0;
		fault_and_refresh(32'h3004);
		// History is empty now, so r5 comes from the issue
		issue = make_issue(ADD, 32'd40, 32'd11);
		issue.src1_ptr = 5'd5;
		next_cycle();
		issue.valid = 1'b0;
		check_value("result.valid", result.valid, 1'b1);
		check_value("result.data after refresh", result.data, 32'd51);
	endtask

	task automatic stop_hold();
		logic [XLEN-1:0] d_exp;
		exe_flags_t f_exp;
		int n;
		// This ADD sets cf, of and zf
		alu_model(ADD, 32'h80000000, 32'h80000000, d_exp, f_exp);
		stop = 1'b1;
		issue = make_issue(ADD, 32'h80000000, 32'h80000000);
		issue.flags_writeback = 1'b1;
		for (n = 0; n < 4; n++) begin
			next_cycle();
			check_value("result.valid", result.valid, 1'b0);
			check_value("flags", flags, flags_exp);
		end
		stop = 1'b0;
		next_cycle();
		issue.valid = 1'b0;
		flags_exp = f_exp;
		check_value("result.valid", result.valid, 1'b1);
		check_value("result.data for held ADD", result.data, d_exp);
		check_value("flags", flags, flags_exp);
		// Division finishing under stop shows no result
		issue = make_issue(DIVU, 32'd90, 32'd9);
		next_cycle();
		issue.valid = 1'b0;
		stop = 1'b1;
		n = 0;
		while (lock && n < RESULT_WAIT) begin
			next_cycle();
			check_value("result.valid", result.valid, 1'b0);
			n++;
		end
		if (lock) begin
			report_failure("lock stayed high after the division under stop");
		end
		stop = 1'b0;
		next_cycle();
		check_value("result.valid", result.valid, 1'b0);
	endtask

	initial begin
		seed = 2001;
		errors = 0;
		checks = 0;
		cycles = 0;
		iCLOCK = 1'b0;
		inRESET = 1'b0;
		issue = '0;
		stop = 1'b0;
		refresh = 1'b0;
		flags_exp = '0;
		repeat (RESET_CYCLES) @(posedge iCLOCK);
		#1;
		inRESET = 1'b1;
		reset_state();
		alu_ops();
		forwarding();
		division();
		divide_by_zero();
		stop_hold();
		next_cycle();
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

/* build.f */
exe_pkg.sv
exe_forward.sv
exe_alu.sv
exe_divider.sv
exe_control.sv
exe_top.sv
tb_exe_top.sv
